// File: design/dbg_cfg_pkg.sv
`default_nettype none

package dbg_cfg_pkg;

  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;

  localparam logic [AXIL_DATA_W-1:0] DBG_ID          = 32'd14552304;
  localparam logic [AXIL_DATA_W-1:0] NUM_SPARSE_DATA = 32'd12;

  localparam int SPPE_LANES = 16;
  localparam int SPPE_LANE  = 2; // lane sampled by both lane captures.

  // control register reset values.
  localparam logic [15:0] CAPT0_ADDR_RST  = 16'd10;
  localparam logic [15:0] CAPT1_ADDR_RST  = 16'd20;
  localparam logic [15:0] FEAT_THRESH_RST = 16'd43328;

  localparam logic [AXIL_ADDR_W-1:0] REG_ID          = 8'h00;
  localparam logic [AXIL_ADDR_W-1:0] REG_CONFIG      = 8'h04;
  localparam logic [AXIL_ADDR_W-1:0] REG_STATUS      = 8'h08;
  localparam logic [AXIL_ADDR_W-1:0] REG_SM_COUNT    = 8'h0C;
  localparam logic [AXIL_ADDR_W-1:0] REG_CAPT0_ADDR  = 8'h10;
  localparam logic [AXIL_ADDR_W-1:0] REG_CAPT1_ADDR  = 8'h14;
  localparam logic [AXIL_ADDR_W-1:0] REG_CAPT0_DATA  = 8'h18;
  localparam logic [AXIL_ADDR_W-1:0] REG_CAPT1_DATA  = 8'h1C;
  localparam logic [AXIL_ADDR_W-1:0] REG_FEAT_DATA   = 8'h20;
  localparam logic [AXIL_ADDR_W-1:0] REG_FEAT_THRESH = 8'h24;
  localparam logic [AXIL_ADDR_W-1:0] REG_CLEAR       = 8'h28; // write only.

  localparam int CLR_STICKY_BIT = 0;
  localparam int CLR_COUNT_BIT  = 1;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: design/dbg_types_pkg.sv
`default_nettype none

package dbg_types_pkg;
  import dbg_cfg_pkg::*;

  // buffer address compared by the captures.
  typedef logic [15:0] probe_key_t;

  typedef logic [11:0] sppe_lane_t;
  typedef sppe_lane_t [SPPE_LANES-1:0] sppe_bus_t;

  typedef logic [AXIL_DATA_W-1:0] feat_word_t;

  // first field is the msb.
  typedef struct packed {
    logic       feat_hit;   // bit 10.
    logic       capt0_hit;  // bit 9.
    logic       feat_seen;  // bit 8.
    logic [7:0] stage;      // spmm_vld down to aggr_rdy.
  } dbg_status_t;

endpackage

`default_nettype wire

// File: design/stage_status_if.sv
`default_nettype none

interface stage_status_if;

  logic spmm_vld;
  logic spmm_rdy;
  logic dmvm_vld;
  logic dmvm_rdy;
  logic sm_vld;
  logic sm_rdy;
  logic aggr_vld;
  logic aggr_rdy;

  modport source (
    output spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy,
    output sm_vld, sm_rdy, aggr_vld, aggr_rdy
  );

  // observer side, never drives the stages.
  modport monitor (
    input spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy,
    input sm_vld, sm_rdy, aggr_vld, aggr_rdy
  );

endinterface

`default_nettype wire

// File: design/stage_monitor.sv
`default_nettype none

module stage_monitor (
  input  wire                 clk,
  input  wire                 rst_n,
  stage_status_if.monitor     st,
  input  wire                 feat_ena_i,
  input  wire                 clr_sticky_i,
  input  wire                 clr_count_i,
  output logic [7:0]          flags_o,
  output logic                feat_seen_o,
  output logic [31:0]         sm_count_o
);

  logic [7:0] stage_now;

  // same order as the status register, aggr_rdy at bit 0.
  assign stage_now = {
    st.spmm_vld, st.spmm_rdy,
    st.dmvm_vld, st.dmvm_rdy,
    st.sm_vld,   st.sm_rdy,
    st.aggr_vld, st.aggr_rdy
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_o     <= '0;
      feat_seen_o <= 1'b0;
    end else if (clr_sticky_i) begin
      // an event in the clear cycle is dropped.
      flags_o     <= '0;
      feat_seen_o <= 1'b0;
    end else begin
      flags_o     <= flags_o | stage_now;
      feat_seen_o <= feat_seen_o | feat_ena_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_count_o <= '0;
    end else if (clr_count_i) begin
      sm_count_o <= '0;
    end else if (st.sm_vld) begin
      sm_count_o <= sm_count_o + 32'd1; // wraps.
    end
  end

endmodule

`default_nettype wire

// File: design/probe_capture.sv
`default_nettype none

module probe_capture
  import dbg_types_pkg::*;
#(
  parameter type payload_t = logic [31:0],
  parameter bit  MATCH_EQ  = 1'b1
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              strobe_i,
  input  wire probe_key_t  key_i,
  input  wire probe_key_t  bound_i,
  input  wire payload_t    payload_i,
  input  wire              clr_i,
  output payload_t         data_o,
  output logic             hit_o
);

  logic key_ok;

  // equal match for lanes, threshold for the feature region.
  assign key_ok = MATCH_EQ ? (key_i == bound_i) : (key_i >= bound_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_o <= '0;
      hit_o  <= 1'b0;
    end else if (clr_i) begin
      data_o <= '0;
      hit_o  <= 1'b0;
    end else if (strobe_i && key_ok) begin
      data_o <= payload_i; // last match wins.
      hit_o  <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/dbg_axil_regs.sv
`default_nettype none

module dbg_axil_regs
  import dbg_cfg_pkg::*;
  import dbg_types_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire [AXIL_ADDR_W-1:0]  s_awaddr_i,
  input  wire                    s_awvalid_i,
  output logic                   s_awready_o,
  input  wire [AXIL_DATA_W-1:0]  s_wdata_i,
  input  wire [3:0]              s_wstrb_i,
  input  wire                    s_wvalid_i,
  output logic                   s_wready_o,
  output logic [1:0]             s_bresp_o,
  output logic                   s_bvalid_o,
  input  wire                    s_bready_i,
  input  wire [AXIL_ADDR_W-1:0]  s_araddr_i,
  input  wire                    s_arvalid_i,
  output logic                   s_arready_o,
  output logic [AXIL_DATA_W-1:0] s_rdata_o,
  output logic [1:0]             s_rresp_o,
  output logic                   s_rvalid_o,
  input  wire                    s_rready_i,
  input  wire dbg_status_t       status_i,
  input  wire [AXIL_DATA_W-1:0]  sm_count_i,
  input  wire sppe_lane_t        capt0_data_i,
  input  wire sppe_lane_t        capt1_data_i,
  input  wire feat_word_t        feat_data_i,
  output probe_key_t             capt0_addr_o,
  output probe_key_t             capt1_addr_o,
  output probe_key_t             feat_thresh_o,
  output logic                   clr_sticky_o,
  output logic                   clr_count_o
);

  logic                   wr_rdy_q;
  logic                   wr_hs;
  logic                   wr_ok;
  logic                   rd_hs;
  logic                   rd_err;
  logic [AXIL_DATA_W-1:0] rd_word;

  function automatic probe_key_t merge_bytes(probe_key_t cur, logic [AXIL_DATA_W-1:0] din,
                                             logic [3:0] strb);
    probe_key_t res;
    res = cur;
    for (int b = 0; b < $bits(probe_key_t) / 8; b++) begin
      if (strb[b]) res[8*b +: 8] = din[8*b +: 8];
    end
    return res;
  endfunction

  assign s_awready_o = wr_rdy_q;
  assign s_wready_o  = wr_rdy_q;
  assign wr_hs       = wr_rdy_q && s_awvalid_i && s_wvalid_i;
  assign wr_ok       = s_awaddr_i inside {REG_CAPT0_ADDR, REG_CAPT1_ADDR, REG_FEAT_THRESH,
                                          REG_CLEAR};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_rdy_q      <= 1'b0;
      s_bvalid_o    <= 1'b0;
      clr_sticky_o  <= 1'b0;
      clr_count_o   <= 1'b0;
      capt0_addr_o  <= CAPT0_ADDR_RST;
      capt1_addr_o  <= CAPT1_ADDR_RST;
      feat_thresh_o <= FEAT_THRESH_RST;
    end else begin
      // one-cycle ready, held off while a response waits.
      wr_rdy_q     <= s_awvalid_i && s_wvalid_i && !wr_rdy_q && !s_bvalid_o;
      clr_sticky_o <= 1'b0;
      clr_count_o  <= 1'b0;
      if (wr_hs) begin
        s_bvalid_o <= 1'b1;
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
      if (wr_hs && wr_ok) begin
        case (s_awaddr_i)
          REG_CAPT0_ADDR:  capt0_addr_o  <= merge_bytes(capt0_addr_o, s_wdata_i, s_wstrb_i);
          REG_CAPT1_ADDR:  capt1_addr_o  <= merge_bytes(capt1_addr_o, s_wdata_i, s_wstrb_i);
          REG_FEAT_THRESH: feat_thresh_o <= merge_bytes(feat_thresh_o, s_wdata_i, s_wstrb_i);
          default: begin
            if (s_wstrb_i[0]) begin
              clr_sticky_o <= s_wdata_i[CLR_STICKY_BIT];
              clr_count_o  <= s_wdata_i[CLR_COUNT_BIT];
            end
          end
        endcase
      end
    end
  end

  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (s_araddr_i)
      REG_ID:          rd_word = DBG_ID;
      REG_CONFIG:      rd_word = NUM_SPARSE_DATA;
      REG_STATUS:      rd_word = AXIL_DATA_W'(status_i);
      REG_SM_COUNT:    rd_word = sm_count_i;
      REG_CAPT0_ADDR:  rd_word = AXIL_DATA_W'(capt0_addr_o);
      REG_CAPT1_ADDR:  rd_word = AXIL_DATA_W'(capt1_addr_o);
      REG_CAPT0_DATA:  rd_word = AXIL_DATA_W'(capt0_data_i);
      REG_CAPT1_DATA:  rd_word = AXIL_DATA_W'(capt1_data_i);
      REG_FEAT_DATA:   rd_word = feat_data_i;
      REG_FEAT_THRESH: rd_word = AXIL_DATA_W'(feat_thresh_o);
      default:         rd_err  = 1'b1; // includes REG_CLEAR.
    endcase
  end

  assign rd_hs = s_arready_o && s_arvalid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b0;
    end else begin
      s_arready_o <= s_arvalid_i && !s_arready_o && !s_rvalid_o;
      if (rd_hs) begin
        s_rvalid_o <= 1'b1;
      end else if (s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
    end
  end

  // response payload, only meaningful under its valid.
  always_ff @(posedge clk) begin
    if (wr_hs) s_bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    if (rd_hs) begin
      s_rdata_o <= rd_word;
      s_rresp_o <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

// File: design/accel_debugger.sv
`default_nettype none

module accel_debugger
  import dbg_cfg_pkg::*;
  import dbg_types_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    spmm_vld_i,
  input  wire                    spmm_rdy_i,
  input  wire                    dmvm_vld_i,
  input  wire                    dmvm_rdy_i,
  input  wire                    sm_vld_i,
  input  wire                    sm_rdy_i,
  input  wire                    aggr_vld_i,
  input  wire                    aggr_rdy_i,
  input  wire sppe_bus_t         sppe_i,
  input  wire [13:0]             wh_addr_i,
  input  wire feat_word_t        feat_din_i,
  input  wire                    feat_ena_i,
  input  wire probe_key_t        feat_addr_i,
  input  wire [AXIL_ADDR_W-1:0]  s_awaddr_i,
  input  wire                    s_awvalid_i,
  output logic                   s_awready_o,
  input  wire [AXIL_DATA_W-1:0]  s_wdata_i,
  input  wire [3:0]              s_wstrb_i,
  input  wire                    s_wvalid_i,
  output logic                   s_wready_o,
  output logic [1:0]             s_bresp_o,
  output logic                   s_bvalid_o,
  input  wire                    s_bready_i,
  input  wire [AXIL_ADDR_W-1:0]  s_araddr_i,
  input  wire                    s_arvalid_i,
  output logic                   s_arready_o,
  output logic [AXIL_DATA_W-1:0] s_rdata_o,
  output logic [1:0]             s_rresp_o,
  output logic                   s_rvalid_o,
  input  wire                    s_rready_i
);

  dbg_status_t            status;
  logic [AXIL_DATA_W-1:0] sm_count;
  sppe_lane_t             capt0_data;
  sppe_lane_t             capt1_data;
  feat_word_t             feat_data;
  probe_key_t             capt0_addr;
  probe_key_t             capt1_addr;
  probe_key_t             feat_thresh;
  probe_key_t             wh_key;
  logic                   clr_sticky;
  logic                   clr_count;

  stage_status_if st_if ();

  // source side of the stage bundle.
  assign st_if.spmm_vld = spmm_vld_i;
  assign st_if.spmm_rdy = spmm_rdy_i;
  assign st_if.dmvm_vld = dmvm_vld_i;
  assign st_if.dmvm_rdy = dmvm_rdy_i;
  assign st_if.sm_vld   = sm_vld_i;
  assign st_if.sm_rdy   = sm_rdy_i;
  assign st_if.aggr_vld = aggr_vld_i;
  assign st_if.aggr_rdy = aggr_rdy_i;

  assign wh_key = probe_key_t'(wh_addr_i); // zero-extended.

  stage_monitor u_stage_monitor (
    .clk          (clk),
    .rst_n        (rst_n),
    .st           (st_if.monitor),
    .feat_ena_i   (feat_ena_i),
    .clr_sticky_i (clr_sticky),
    .clr_count_i  (clr_count),
    .flags_o      (status.stage),
    .feat_seen_o  (status.feat_seen),
    .sm_count_o   (sm_count)
  );

  probe_capture #(.payload_t(sppe_lane_t), .MATCH_EQ(1'b1)) u_capt0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .strobe_i  (spmm_rdy_i),
    .key_i     (wh_key),
    .bound_i   (capt0_addr),
    .payload_i (sppe_i[SPPE_LANE]),
    .clr_i     (clr_sticky),
    .data_o    (capt0_data),
    .hit_o     (status.capt0_hit)
  );

  // hit of this one is visible only through its data.
  probe_capture #(.payload_t(sppe_lane_t), .MATCH_EQ(1'b1)) u_capt1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .strobe_i  (spmm_rdy_i),
    .key_i     (wh_key),
    .bound_i   (capt1_addr),
    .payload_i (sppe_i[SPPE_LANE]),
    .clr_i     (clr_sticky),
    .data_o    (capt1_data),
    .hit_o     ()
  );

  probe_capture #(.payload_t(feat_word_t), .MATCH_EQ(1'b0)) u_feat_capt (
    .clk       (clk),
    .rst_n     (rst_n),
    .strobe_i  (feat_ena_i),
    .key_i     (feat_addr_i),
    .bound_i   (feat_thresh),
    .payload_i (feat_din_i),
    .clr_i     (clr_sticky),
    .data_o    (feat_data),
    .hit_o     (status.feat_hit)
  );

  dbg_axil_regs u_dbg_axil_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_awaddr_i    (s_awaddr_i),
    .s_awvalid_i   (s_awvalid_i),
    .s_awready_o   (s_awready_o),
    .s_wdata_i     (s_wdata_i),
    .s_wstrb_i     (s_wstrb_i),
    .s_wvalid_i    (s_wvalid_i),
    .s_wready_o    (s_wready_o),
    .s_bresp_o     (s_bresp_o),
    .s_bvalid_o    (s_bvalid_o),
    .s_bready_i    (s_bready_i),
    .s_araddr_i    (s_araddr_i),
    .s_arvalid_i   (s_arvalid_i),
    .s_arready_o   (s_arready_o),
    .s_rdata_o     (s_rdata_o),
    .s_rresp_o     (s_rresp_o),
    .s_rvalid_o    (s_rvalid_o),
    .s_rready_i    (s_rready_i),
    .status_i      (status),
    .sm_count_i    (sm_count),
    .capt0_data_i  (capt0_data),
    .capt1_data_i  (capt1_data),
    .feat_data_i   (feat_data),
    .capt0_addr_o  (capt0_addr),
    .capt1_addr_o  (capt1_addr),
    .feat_thresh_o (feat_thresh),
    .clr_sticky_o  (clr_sticky),
    .clr_count_o   (clr_count)
  );

endmodule

`default_nettype wire

// File: tb/tb_accel_debugger.sv
`default_nettype none

module tb_accel_debugger
  import dbg_cfg_pkg::*;
  import dbg_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 64;

  logic                   clk;
  logic                   rst_n;
  logic                   spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy;
  logic                   sm_vld, sm_rdy, aggr_vld, aggr_rdy;
  sppe_bus_t              sppe;
  logic [13:0]            wh_addr;
  feat_word_t             feat_din;
  logic                   feat_ena;
  probe_key_t             feat_addr;
  logic [AXIL_ADDR_W-1:0] s_awaddr, s_araddr;
  logic                   s_awvalid, s_awready, s_wvalid, s_wready;
  logic [AXIL_DATA_W-1:0] s_wdata, s_rdata;
  logic [3:0]             s_wstrb;
  logic [1:0]             s_bresp, s_rresp;
  logic                   s_bvalid, s_bready, s_arvalid, s_arready, s_rvalid, s_rready;
  integer                 seed = 33250;

  always #2 clk = ~clk;

  accel_debugger u_accel_debugger (
    .clk         (clk),
    .rst_n       (rst_n),
    .spmm_vld_i  (spmm_vld),
    .spmm_rdy_i  (spmm_rdy),
    .dmvm_vld_i  (dmvm_vld),
    .dmvm_rdy_i  (dmvm_rdy),
    .sm_vld_i    (sm_vld),
    .sm_rdy_i    (sm_rdy),
    .aggr_vld_i  (aggr_vld),
    .aggr_rdy_i  (aggr_rdy),
    .sppe_i      (sppe),
    .wh_addr_i   (wh_addr),
    .feat_din_i  (feat_din),
    .feat_ena_i  (feat_ena),
    .feat_addr_i (feat_addr),
    .s_awaddr_i  (s_awaddr),
    .s_awvalid_i (s_awvalid),
    .s_awready_o (s_awready),
    .s_wdata_i   (s_wdata),
    .s_wstrb_i   (s_wstrb),
    .s_wvalid_i  (s_wvalid),
    .s_wready_o  (s_wready),
    .s_bresp_o   (s_bresp),
    .s_bvalid_o  (s_bvalid),
    .s_bready_i  (s_bready),
    .s_araddr_i  (s_araddr),
    .s_arvalid_i (s_arvalid),
    .s_arready_o (s_arready),
    .s_rdata_o   (s_rdata),
    .s_rresp_o   (s_rresp),
    .s_rvalid_o  (s_rvalid),
    .s_rready_i  (s_rready)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input [8*24-1:0] tname, input string field,
                                 input [31:0] exp, input [31:0] got);
    abort_run($sformatf("[FAIL] %0s %0s: expected %h, actual %h", tname, field, exp, got));
  endtask

  task automatic axi_write(input [8*24-1:0] tname, input [7:0] addr, input [31:0] data,
                           input [1:0] exp_resp);
    int cnt;
    @(posedge clk);
    s_awaddr  <= addr;
    s_wdata   <= data;
    s_wstrb   <= 4'hf;
    s_awvalid <= 1'b1;
    s_wvalid  <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) abort_run($sformatf("%0s: write was never accepted", tname));
    end while (!s_awready);
    assert (s_wready)
      else abort_run($sformatf("%0s: wready did not rise together with awready", tname));
    @(posedge clk); // handshake edge.
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) abort_run($sformatf("%0s: no write response", tname));
    end while (!s_bvalid);
    assert (s_bresp == exp_resp)
      else report_mismatch(tname, "bresp", 32'(exp_resp), 32'(s_bresp));
  endtask

  task automatic axi_read(input [8*24-1:0] tname, input [7:0] addr, input [31:0] exp_data,
                          input [1:0] exp_resp);
    int cnt;
    @(posedge clk);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) abort_run($sformatf("%0s: read was never accepted", tname));
    end while (!s_arready);
    @(posedge clk);
    s_arvalid <= 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) abort_run($sformatf("%0s: no read data", tname));
    end while (!s_rvalid);
    assert (s_rdata == exp_data) else report_mismatch(tname, "rdata", exp_data, s_rdata);
    assert (s_rresp == exp_resp)
      else report_mismatch(tname, "rresp", 32'(exp_resp), 32'(s_rresp));
  endtask

  task automatic pulse_stages(input [7:0] mask);
    @(posedge clk);
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy, sm_vld, sm_rdy, aggr_vld, aggr_rdy} <= mask;
    @(posedge clk);
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy, sm_vld, sm_rdy, aggr_vld, aggr_rdy} <= 8'h00;
  endtask

  task automatic run_softmax(input [31:0] n);
    @(posedge clk);
    sm_vld <= 1'b1;
    repeat (n) @(posedge clk);
    sm_vld <= 1'b0;
  endtask

  task automatic drive_lane(input [13:0] waddr, input [11:0] value, input logic rdy);
    sppe_bus_t bus;
    for (int i = 0; i < SPPE_LANES; i++) begin
      bus[i] = sppe_lane_t'($random(seed)); // other lanes are noise.
    end
    bus[SPPE_LANE] = value;
    @(posedge clk);
    sppe     <= bus;
    wh_addr  <= waddr;
    spmm_rdy <= rdy;
    @(posedge clk);
    spmm_rdy <= 1'b0;
  endtask

  task automatic write_feature(input [15:0] addr, input [31:0] data, input logic ena);
    @(posedge clk);
    feat_addr <= addr;
    feat_din  <= data;
    feat_ena  <= ena;
    @(posedge clk);
    feat_ena  <= 1'b0;
  endtask

  initial begin
    integer          fd;
    integer          code;
    integer          nargs;
    int              ntests;
    logic [8*128-1:0] line;
    logic [8*24-1:0]  tname;
    logic [8*8-1:0]   cmd;
    logic [31:0]      a0, a1, a2;
    clk       = 1'b0;
    rst_n     = 1'b0;
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy} = 4'h0;
    {sm_vld, sm_rdy, aggr_vld, aggr_rdy}     = 4'h0;
    sppe      = '0;
    wh_addr   = '0;
    feat_din  = '0;
    feat_ena  = 1'b0;
    feat_addr = '0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wstrb   = 4'h0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b1;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b1;
    ntests    = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    fd = $fopen("tb/debug_tests.txt", "r");
    if (fd == 0) abort_run("cannot open tb/debug_tests.txt");
    while (!$feof(fd)) begin
      code  = $fgets(line, fd);
      nargs = $sscanf(line, "%s %s %h %h %h", tname, cmd, a0, a1, a2);
      if (code == 0 || nargs < 2 || tname == "#") continue; // blank or comment.
      ntests++;
      case (cmd)
        "WR":    axi_write(tname, a0[7:0], a1, a2[1:0]);
        "RD":    axi_read(tname, a0[7:0], a1, a2[1:0]);
        "STAGE": pulse_stages(a0[7:0]);
        "SM":    run_softmax(a0);
        "LANE":  drive_lane(a0[13:0], a1[11:0], a2[0]);
        "FEAT":  write_feature(a0[15:0], a1, a2[0]);
        default: abort_run($sformatf("unknown command %0s in test %0s", cmd, tname));
      endcase
    end
    $fclose(fd);

    if (ntests == 0) begin
      abort_run("no test lines found in tb/debug_tests.txt");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: accel_debugger.f
design/dbg_cfg_pkg.sv
design/dbg_types_pkg.sv
design/stage_status_if.sv
design/stage_monitor.sv
design/probe_capture.sv
design/dbg_axil_regs.sv
design/accel_debugger.sv
tb/tb_accel_debugger.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f accel_debugger.f \
  --top-module tb_accel_debugger -o tb_accel_debugger_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_accel_debugger_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb/debug_tests.txt
# columns: name command arg0 arg1 arg2, all args in hex
# WR/RD offset data resp, STAGE mask, SM cycles, LANE waddr value rdy, FEAT addr data ena
rst_id        RD    00   00DE0CF0 0
rst_config    RD    04   0000000C 0
rst_status    RD    08   00000000 0
rst_capt0     RD    10   0000000A 0
rst_thresh    RD    24   0000A940 0
stg_a         STAGE 81   0        0
stg_b         STAGE 24   0        0
stg_c         STAGE 81   0        0
stg_status    RD    08   000000A5 0
stg_clear     WR    28   00000001 0
stg_cleared   RD    08   00000000 0
sm_a          SM    5    0        0
sm_b          SM    3    0        0
sm_count      RD    0C   00000008 0
sm_clear      WR    28   00000002 0
sm_zero       RD    0C   00000000 0
sm_flags_kept RD    08   00000008 0
ln_match      LANE  000A 00000123 1
ln_no_rdy     LANE  000A 00000456 0
ln_other      LANE  000B 00000789 1
ln_capt1      LANE  0014 00000ABC 1
ln_capt0_rd   RD    18   00000123 0
ln_capt1_rd   RD    1C   00000ABC 0
ln_status     RD    08   00000248 0
ln_move       WR    14   0000000B 0
ln_new_match  LANE  000B 000005A5 1
ln_old_addr   LANE  0014 00000111 1
ln_capt1_new  RD    1C   000005A5 0
ln_capt0_kept RD    18   00000123 0
ft_clear      WR    28   00000001 0
ft_status0    RD    08   00000000 0
ft_below      FEAT  A93F 11111111 1
ft_none       RD    20   00000000 0
ft_seen       RD    08   00000100 0
ft_at         FEAT  A940 22222222 1
ft_no_ena     FEAT  FFFF 33333333 0
ft_high       FEAT  C000 44444444 1
ft_low        FEAT  0010 55555555 1
ft_data       RD    20   44444444 0
ft_status     RD    08   00000500 0
err_unmapped  RD    2C   00000000 2
err_clear_rd  RD    28   00000000 2
err_wr_id     WR    00   12345678 2
err_id_kept   RD    00   00DE0CF0 0
